// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/1ps
TOP       = tb_u2_ctrl
FILELIST  = project.f
OBJ_DIR   = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: project.f
verilog/u2_ctrl_pkg.sv
verilog/setting_reg.sv
verilog/misc_ctrl_regs.sv
verilog/simple_timer.sv
verilog/time_64bit.sv
verilog/readback_mux.sv
verilog/u2_ctrl_core.sv
tb/tb_u2_ctrl.sv

// File: tb/tb_u2_ctrl.sv
/*
 * Radio core slow-control testbench
 * Directed tests of control registers, LED select, readback,
 * timers and VITA time through the settings and readback strobes
 */
module tb_u2_ctrl
   import u2_ctrl_pkg::*;
();
   timeunit 1ns;
   timeprecision 1ps;

   localparam int CLK_PERIOD = 40;
   localparam int TICKS      = 1000;
   // Cycle budget per test, doubled for the watchdog
   localparam int TEST_CYCLES = 10 + 30 + 20 + 60 + 160 + 50;
   localparam int WATCHDOG_NS = 2 * TEST_CYCLES * CLK_PERIOD;

   logic       dsp_clk = 1'b0;
   logic       reset_i;
   logic       set_stb_i;
   set_addr_t  set_addr_i;
   set_data_t  set_data_i;
   logic       rb_stb_i;
   rb_addr_t   rb_addr_i;
   logic       pps_i, clk_status_i, serdes_link_up_i, phy_intn_i, sim_mode_i;
   logic [3:0] clock_divider_i;
   rb_word_t   rb_data_o;
   logic       rb_ack_o, clock_ready_o, phy_resetn_o;
   logic [1:0] clk_en_o, clk_sel_o;
   logic       ser_enable_o, ser_prbsen_o, ser_loopen_o, ser_rx_en_o;
   logic       adc_oe_a_o, adc_on_a_o, adc_oe_b_o, adc_on_b_o;
   led_t       leds_o;
   logic       onetime_int_o, periodic_int_o, pps_int_o;

   integer seed = 32'h920c;
   int     cyc = 0;
   int     wr_cyc;
   int     rb_cyc;

   u2_ctrl_core #(.ticks_per_sec(TICKS)) uut (.*);

   always #(CLK_PERIOD / 2) dsp_clk = ~dsp_clk;

   // Cycle number, read only at the falling edge
   always @(posedge dsp_clk) cyc <= cyc + 1;

   //////////////////////////////
   // Checks
   //////////////////////////////
   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("Simulation FAILED");
      $fatal(1);
   endtask

   task automatic check_word(input string what, input rb_word_t got, input rb_word_t exp);
      if (got !== exp)
         abort_run($sformatf("Mismatch at time %0t: %s got %h expected %h", $time, what, got, exp));
   endtask

   task automatic check_leds(input string what, input led_t got, input led_t exp);
      if (got !== exp)
         abort_run($sformatf("Mismatch at time %0t: %s got %b expected %b", $time, what, got, exp));
   endtask

   task automatic check_time(input string what, input vita_time_t got, input vita_time_t exp);
      if (got !== exp)
         abort_run($sformatf("Mismatch at time %0t: %s got %h expected %h", $time, what, got, exp));
   endtask

   task automatic check_bit(input string what, input logic got, input logic exp);
      if (got !== exp)
         abort_run($sformatf("Mismatch at time %0t: %s got %b expected %b", $time, what, got, exp));
   endtask

   //////////////////////////////
   // Bus handshakes
   //////////////////////////////
   task automatic write_setting(input set_addr_t addr, input set_data_t data);
      @(posedge dsp_clk);
      set_stb_i  <= 1'b1;
      set_addr_i <= addr;
      set_data_i <= data;
      @(negedge dsp_clk);
      wr_cyc = cyc;
      @(posedge dsp_clk);
      set_stb_i <= 1'b0;
   endtask

   // Ack must be low in the strobe cycle and high in the next one
   task automatic read_word(input rb_addr_t addr, output rb_word_t data);
      @(posedge dsp_clk);
      rb_stb_i  <= 1'b1;
      rb_addr_i <= addr;
      @(negedge dsp_clk);
      rb_cyc = cyc;
      check_bit("rb_ack_o in strobe cycle", rb_ack_o, 1'b0);
      @(posedge dsp_clk);
      rb_stb_i <= 1'b0;
      @(negedge dsp_clk);
      check_bit("rb_ack_o after strobe", rb_ack_o, 1'b1);
      data = rb_data_o;
   endtask

   // One tick per cycle, seconds step when ticks wraps
   function automatic vita_time_t advance_time(input vita_time_t t, input int n);
      vita_time_t r;
      r = t;
      for (int i = 0; i < n; i++) begin
         if (r.ticks == TICKS - 1) begin
            r.ticks = '0;
            r.secs  = r.secs + 1;
         end else begin
            r.ticks = r.ticks + 1;
         end
      end
      return r;
   endfunction

   function automatic rb_word_t control_pins();
      return {18'b0, clock_ready_o, clk_en_o, clk_sel_o,
              ser_enable_o, ser_prbsen_o, ser_loopen_o, ser_rx_en_o,
              adc_oe_a_o, adc_on_a_o, adc_oe_b_o, adc_on_b_o, phy_resetn_o};
   endfunction

   // Walks the status inputs and applies the per-bit select
   task automatic check_led_select(input led_t sw, input led_t src);
      led_t hw;
      led_t exp;
      for (int s = 0; s < 4; s++) begin
         @(posedge dsp_clk);
         clk_status_i     <= s[1];
         serdes_link_up_i <= s[0];
         @(negedge dsp_clk);
         hw    = '0;
         hw[2] = clk_status_i;
         hw[1] = serdes_link_up_i;
         for (int b = 0; b < 8; b++) exp[b] = src[b] ? hw[b] : sw[b];
         check_leds("leds_o", leds_o, exp);
      end
   endtask

   // Pulse expected k cycles after the write, period 0 means none
   task automatic expect_pulses(input bit periodic, input int start, input int period,
                                input int span);
      int   k;
      logic got;
      logic exp;
      repeat (span) begin
         @(negedge dsp_clk);
         k   = cyc - start;
         got = periodic ? periodic_int_o : onetime_int_o;
         if (period == 0) exp = 1'b0;
         else if (periodic) exp = (k > 0) && (k % period == 0);
         else exp = (k == period);
         check_bit(periodic ? "periodic_int_o" : "onetime_int_o", got, exp);
      end
   endtask

   //////////////////////////////
   // Tests
   //////////////////////////////
   task automatic test_reset();
      @(negedge dsp_clk);
      check_word("control pins after reset", control_pins(), 32'h1);
      check_bit("onetime_int_o", onetime_int_o, 1'b0);
      check_bit("periodic_int_o", periodic_int_o, 1'b0);
      check_bit("pps_int_o", pps_int_o, 1'b0);
      check_bit("rb_ack_o", rb_ack_o, 1'b0);
      check_led_select(8'h00, LED_SRC_RESET);
   endtask

   task automatic test_control_regs();
      set_data_t r;
      rb_word_t  snap;
      led_t      leds_snap;
      r = $random(seed);
      write_setting(set_addr_t'(SR_MISC + 0), r);
      @(negedge dsp_clk);
      check_word("clock pins", rb_word_t'({clock_ready_o, clk_en_o, clk_sel_o}),
                 rb_word_t'(r[4:0]));
      r = $random(seed);
      write_setting(set_addr_t'(SR_MISC + 1), r);
      @(negedge dsp_clk);
      check_word("serdes pins", rb_word_t'({ser_enable_o, ser_prbsen_o, ser_loopen_o,
                 ser_rx_en_o}), rb_word_t'(r[3:0]));
      r = $random(seed);
      write_setting(set_addr_t'(SR_MISC + 2), r);
      @(negedge dsp_clk);
      check_word("adc pins", rb_word_t'({adc_oe_a_o, adc_on_a_o, adc_oe_b_o, adc_on_b_o}),
                 rb_word_t'(r[3:0]));
      r = $random(seed);
      write_setting(set_addr_t'(SR_MISC + 4), r);
      @(negedge dsp_clk);
      check_bit("phy_resetn_o", phy_resetn_o, ~r[0]);
      snap      = control_pins();
      leds_snap = leds_o;
      write_setting(set_addr_t'(SR_MISC + 5), $random(seed));
      write_setting(set_addr_t'(SR_MISC + 7), $random(seed));
      write_setting(8'd200, $random(seed));
      @(negedge dsp_clk);
      check_word("pins after unused writes", control_pins(), snap);
      check_leds("leds after unused writes", leds_o, leds_snap);
   endtask

   task automatic test_led_mux();
      led_t sw;
      led_t src;
      repeat (2) begin
         sw  = led_t'($random(seed));
         src = led_t'($random(seed));
         write_setting(set_addr_t'(SR_MISC + 3), set_data_t'(sw));
         write_setting(set_addr_t'(SR_MISC + 6), set_data_t'(src));
         check_led_select(sw, src);
      end
   endtask

   task automatic test_readback();
      rb_word_t w;
      rb_word_t exp;
      read_word(RB_COMPAT, w);
      check_word("compat word", w, 32'd6);
      // Sim mode low, then high
      for (int m = 0; m < 2; m++) begin
         @(posedge dsp_clk);
         sim_mode_i      <= m[0];
         clock_divider_i <= 4'(($random(seed)));
         read_word(RB_SIM, w);
         exp       = '0;
         exp[31]   = sim_mode_i;
         exp[3:0]  = clock_divider_i;
         check_word("sim word", w, exp);
      end
      for (int a = 0; a < 9; a++) begin
         read_word(rb_addr_t'(a), w);
         check_word($sformatf("unused word %0d", a), w, 32'h0);
      end
      // Interrupt word with the timers idle
      for (int s = 0; s < 8; s++) begin
         @(posedge dsp_clk);
         clk_status_i     <= s[2];
         serdes_link_up_i <= s[1];
         phy_intn_i       <= s[0];
         read_word(RB_IRQ, w);
         exp     = '0;
         exp[11] = s[2];
         exp[10] = s[1];
         exp[4]  = ~s[0];
         check_word("irq word", w, exp);
      end
   endtask

   task automatic test_timers();
      int n;
      int p;
      n = ($random(seed) & 15) + 3;
      write_setting(set_addr_t'(SR_SIMTIMER + 0), set_data_t'(n));
      expect_pulses(1'b0, wr_cyc, n, n + 4);
      write_setting(set_addr_t'(SR_SIMTIMER + 0), 32'd20);
      write_setting(set_addr_t'(SR_SIMTIMER + 0), 32'd0);
      expect_pulses(1'b0, wr_cyc, 0, 25);
      p = ($random(seed) & 7) + 2;
      write_setting(set_addr_t'(SR_SIMTIMER + 1), set_data_t'(p));
      expect_pulses(1'b1, wr_cyc, p, 4 * p + 1);
      write_setting(set_addr_t'(SR_SIMTIMER + 1), 32'd0);
      expect_pulses(1'b1, wr_cyc, 0, 2 * p + 2);
   endtask

   task automatic test_vita_time();
      vita_time_t h1;
      vita_time_t h2;
      vita_time_t exp;
      vita_time_t lo_exp;
      rb_word_t   hi;
      rb_word_t   lo;
      int         load_cyc;
      int         lo_cyc;
      int         pps_cyc;
      int         waited;
      // Immediate load close to the end of a second
      h1.secs  = $random(seed);
      h1.ticks = 32'd998;
      write_setting(set_addr_t'(SR_TIME64 + 0), h1.secs);
      write_setting(set_addr_t'(SR_TIME64 + 1), h1.ticks);
      write_setting(set_addr_t'(SR_TIME64 + 2), 32'd1);
      load_cyc = wr_cyc + 1;
      read_word(RB_TIME_LO, lo);
      lo_cyc = rb_cyc;
      read_word(RB_TIME_HI, hi);
      exp       = advance_time(h1, rb_cyc - load_cyc);
      lo_exp    = advance_time(h1, lo_cyc - load_cyc);
      exp.ticks = lo_exp.ticks;
      check_time("time after immediate load", {hi, lo}, exp);
      // Load armed for the next PPS edge
      h2.secs  = $random(seed);
      h2.ticks = 32'd5;
      write_setting(set_addr_t'(SR_TIME64 + 0), h2.secs);
      write_setting(set_addr_t'(SR_TIME64 + 1), h2.ticks);
      write_setting(set_addr_t'(SR_TIME64 + 2), 32'd0);
      @(posedge dsp_clk);
      pps_i <= 1'b1;
      waited = 0;
      @(negedge dsp_clk);
      while (!pps_int_o && waited < 8) begin
         @(negedge dsp_clk);
         waited++;
      end
      if (!pps_int_o) abort_run("Timeout: pps_int_o did not follow pps_i within 8 cycles");
      pps_cyc = cyc;
      // Ticks read in the cycle right after the PPS marker
      read_word(RB_TIME_LO, lo);
      lo_cyc = rb_cyc;
      read_word(RB_TIME_HI, hi);
      exp       = advance_time(h2, rb_cyc - pps_cyc - 1);
      lo_exp    = advance_time(h2, lo_cyc - pps_cyc - 1);
      exp.ticks = lo_exp.ticks;
      check_time("time after PPS load", {hi, lo}, exp);
      read_word(RB_PPS_HI, hi);
      read_word(RB_PPS_LO, lo);
      check_time("PPS capture", {hi, lo}, advance_time(h1, pps_cyc - load_cyc));
      @(posedge dsp_clk);
      pps_i <= 1'b0;
   endtask

   //////////////////////////////
   // Run
   //////////////////////////////
   initial begin
      #(WATCHDOG_NS);
      abort_run("Timeout: watchdog expired before the tests finished");
   end

   initial begin
      reset_i          = 1'b1;
      set_stb_i        = 1'b0;
      set_addr_i       = '0;
      set_data_i       = '0;
      rb_stb_i         = 1'b0;
      rb_addr_i        = '0;
      pps_i            = 1'b0;
      clk_status_i     = 1'b0;
      serdes_link_up_i = 1'b0;
      phy_intn_i       = 1'b1;
      sim_mode_i       = 1'b0;
      clock_divider_i  = '0;
      repeat (3) @(posedge dsp_clk);
      reset_i <= 1'b0;
      test_reset();
      test_control_regs();
      test_led_mux();
      test_readback();
      test_timers();
      test_vita_time();
      $display("Simulation PASSED");
      $finish;
   end

endmodule

// File: verilog/misc_ctrl_regs.sv
/*
 * Misc control registers
 * Clock generator, SERDES, ADC and PHY reset controls, plus the
 * per-bit LED select between hardware status and software value
 */
module misc_ctrl_regs
   import u2_ctrl_pkg::*;
(
   input  logic         dsp_clk,
   input  logic         reset_i,
   input  logic         set_stb_i,
   input  set_addr_t    set_addr_i,
   input  set_data_t    set_data_i,
   input  logic         clk_status_i,
   input  logic         serdes_link_up_i,
   output clock_ctrl_t  clock_ctrl_o,
   output serdes_ctrl_t serdes_ctrl_o,
   output adc_ctrl_t    adc_ctrl_o,
   output logic         phy_resetn_o,
   output led_t         leds_o
);

   led_t led_sw;
   led_t led_src;
   led_t led_hw;
   logic phy_reset;

   //////////////////////////////
   // Pin control registers
   //////////////////////////////
   setting_reg #(.payload_t(clock_ctrl_t), .my_addr(set_addr_t'(SR_MISC + 0))) sr_clk (
      .dsp_clk, .reset_i, .set_stb_i, .set_addr_i, .set_data_i, .out_o(clock_ctrl_o)
   );

   setting_reg #(.payload_t(serdes_ctrl_t), .my_addr(set_addr_t'(SR_MISC + 1))) sr_ser (
      .dsp_clk, .reset_i, .set_stb_i, .set_addr_i, .set_data_i, .out_o(serdes_ctrl_o)
   );

   setting_reg #(.payload_t(adc_ctrl_t), .my_addr(set_addr_t'(SR_MISC + 2))) sr_adc (
      .dsp_clk, .reset_i, .set_stb_i, .set_addr_i, .set_data_i, .out_o(adc_ctrl_o)
   );

   // Register is active high, the pin is active low
   setting_reg #(.payload_t(logic), .my_addr(set_addr_t'(SR_MISC + 4))) sr_phy (
      .dsp_clk, .reset_i, .set_stb_i, .set_addr_i, .set_data_i, .out_o(phy_reset)
   );

   assign phy_resetn_o = ~phy_reset;

   //////////////////////////////
   // LEDs
   //////////////////////////////
   setting_reg #(.payload_t(led_t), .my_addr(set_addr_t'(SR_MISC + 3))) sr_led (
      .dsp_clk, .reset_i, .set_stb_i, .set_addr_i, .set_data_i, .out_o(led_sw)
   );

   // Source bit 1 selects hardware, 0 selects software
   setting_reg #(
      .payload_t(led_t),
      .my_addr  (set_addr_t'(SR_MISC + 6)),
      .at_reset (LED_SRC_RESET)
   ) sr_led_src (
      .dsp_clk, .reset_i, .set_stb_i, .set_addr_i, .set_data_i, .out_o(led_src)
   );

   assign led_hw = {5'b0, clk_status_i, serdes_link_up_i, 1'b0};
   assign leds_o = (led_src & led_hw) | (~led_src & led_sw);

endmodule

// File: verilog/readback_mux.sv
/*
 * Status readback
 * Registered selection of 16 status words, acknowledged one
 * cycle after the request strobe
 */
module readback_mux
   import u2_ctrl_pkg::*;
(
   input  logic       dsp_clk,
   input  logic       reset_i,
   input  logic       rb_stb_i,
   input  rb_addr_t   rb_addr_i,
   input  rb_word_t   sim_word_i,
   input  rb_word_t   irq_word_i,
   input  vita_time_t vita_time_i,
   input  vita_time_t vita_time_pps_i,
   output rb_word_t   rb_data_o,
   output logic       rb_ack_o
);

   rb_word_t word_sel;

   // Words 0 to 8 are unused
   always_comb begin
      case (rb_addr_i)
         RB_SIM:     word_sel = sim_word_i;
         RB_TIME_HI: word_sel = vita_time_i.secs;
         RB_TIME_LO: word_sel = vita_time_i.ticks;
         RB_COMPAT:  word_sel = COMPAT_NUM;
         RB_IRQ:     word_sel = irq_word_i;
         RB_PPS_HI:  word_sel = vita_time_pps_i.secs;
         RB_PPS_LO:  word_sel = vita_time_pps_i.ticks;
         default:    word_sel = '0;
      endcase
   end

   always_ff @(posedge dsp_clk) begin
      if (rb_stb_i) begin
         rb_data_o <= word_sel;
      end
   end

   always_ff @(posedge dsp_clk) begin
      if (reset_i) begin
         rb_ack_o <= 1'b0;
      end else begin
         rb_ack_o <= rb_stb_i;
      end
   end

endmodule

// File: verilog/setting_reg.sv
/*
 * Settings register
 * Holds one payload loaded from the low data bits when the
 * strobed address matches its own
 */
module setting_reg
   import u2_ctrl_pkg::*;
#(
   parameter type       payload_t = set_data_t,
   parameter set_addr_t my_addr   = '0,
   parameter payload_t  at_reset  = '0
) (
   input  logic      dsp_clk,
   input  logic      reset_i,
   input  logic      set_stb_i,
   input  set_addr_t set_addr_i,
   input  set_data_t set_data_i,
   output payload_t  out_o
);

   localparam int PW = $bits(payload_t);

   always_ff @(posedge dsp_clk) begin
      if (reset_i) begin
         out_o <= at_reset;
      end else if (set_stb_i && (set_addr_i == my_addr)) begin
         out_o <= payload_t'(set_data_i[PW-1:0]);
      end
   end

endmodule

// File: verilog/simple_timer.sv
/*
 * Simple timer
 * One-time countdown interrupt and a periodic interrupt, both
 * loaded from the settings bus
 */
module simple_timer
   import u2_ctrl_pkg::*;
(
   input  logic      dsp_clk,
   input  logic      reset_i,
   input  logic      set_stb_i,
   input  set_addr_t set_addr_i,
   input  set_data_t set_data_i,
   output logic      onetime_int_o,
   output logic      periodic_int_o
);

   set_data_t onetime_cnt;
   set_data_t period;
   set_data_t periodic_cnt;
   logic      onetime_wr;
   logic      period_wr;

   assign onetime_wr = set_stb_i && (set_addr_i == set_addr_t'(SR_SIMTIMER + 0));
   assign period_wr  = set_stb_i && (set_addr_i == set_addr_t'(SR_SIMTIMER + 1));

   // Count of N fires N cycles after the write, zero is idle
   always_ff @(posedge dsp_clk) begin
      if (reset_i) begin
         onetime_cnt <= '0;
      end else if (onetime_wr) begin
         onetime_cnt <= set_data_i;
      end else if (onetime_cnt != '0) begin
         onetime_cnt <= onetime_cnt - 32'd1;
      end
   end

   assign onetime_int_o = (onetime_cnt == 32'd1);

   // Reload from the period on every tick, period of zero stops it
   always_ff @(posedge dsp_clk) begin
      if (reset_i) begin
         period       <= '0;
         periodic_cnt <= '0;
      end else if (period_wr) begin
         period       <= set_data_i;
         periodic_cnt <= set_data_i;
      end else if (periodic_cnt == 32'd1) begin
         periodic_cnt <= period;
      end else if (periodic_cnt != '0) begin
         periodic_cnt <= periodic_cnt - 32'd1;
      end
   end

   assign periodic_int_o = (periodic_cnt == 32'd1);

endmodule

// File: verilog/time_64bit.sv
/*
 * VITA time counter
 * Seconds and ticks counter with PPS synchronizer, time capture
 * at PPS, and an immediate or PPS-armed load of a held time
 */
module time_64bit
   import u2_ctrl_pkg::*;
#(
   parameter int unsigned ticks_per_sec = TICKS_PER_SEC_DEFAULT
) (
   input  logic       dsp_clk,
   input  logic       reset_i,
   input  logic       set_stb_i,
   input  set_addr_t  set_addr_i,
   input  set_data_t  set_data_i,
   input  logic       pps_i,
   output vita_time_t vita_time_o,
   output vita_time_t vita_time_pps_o,
   output logic       pps_int_o
);

   localparam set_data_t LAST_TICK = set_data_t'(ticks_per_sec - 1);

   set_data_t  secs_hold;
   set_data_t  ticks_hold;
   vita_time_t held_time;
   vita_time_t vita_next;
   logic       commit_wr;
   logic       load_armed;
   logic [1:0] pps_sync;
   logic       pps_del;

   //////////////////////////////
   // Pending load value
   //////////////////////////////
   setting_reg #(.payload_t(set_data_t), .my_addr(set_addr_t'(SR_TIME64 + 0))) sr_secs (
      .dsp_clk, .reset_i, .set_stb_i, .set_addr_i, .set_data_i, .out_o(secs_hold)
   );

   setting_reg #(.payload_t(set_data_t), .my_addr(set_addr_t'(SR_TIME64 + 1))) sr_ticks (
      .dsp_clk, .reset_i, .set_stb_i, .set_addr_i, .set_data_i, .out_o(ticks_hold)
   );

   assign held_time = {secs_hold, ticks_hold};
   assign commit_wr = set_stb_i && (set_addr_i == set_addr_t'(SR_TIME64 + 2));

   //////////////////////////////
   // PPS edge
   //////////////////////////////
   always_ff @(posedge dsp_clk) begin
      if (reset_i) begin
         pps_sync  <= '0;
         pps_del   <= 1'b0;
         pps_int_o <= 1'b0;
      end else begin
         pps_sync  <= {pps_sync[0], pps_i};
         pps_del   <= pps_sync[1];
         pps_int_o <= pps_sync[1] & ~pps_del;
      end
   end

   // Time of the PPS cycle
   always_ff @(posedge dsp_clk) begin
      if (pps_int_o) begin
         vita_time_pps_o <= vita_time_o;
      end
   end

   //////////////////////////////
   // Counter
   //////////////////////////////
   always_comb begin
      vita_next = vita_time_o;
      if (vita_time_o.ticks == LAST_TICK) begin
         vita_next.ticks = '0;
         vita_next.secs  = vita_time_o.secs + 32'd1;
      end else begin
         vita_next.ticks = vita_time_o.ticks + 32'd1;
      end
   end

   // Commit bit 0 set loads now, clear waits for the next PPS
   always_ff @(posedge dsp_clk) begin
      if (reset_i) begin
         vita_time_o <= '0;
         load_armed  <= 1'b0;
      end else begin
         if (commit_wr && set_data_i[0]) begin
            vita_time_o <= held_time;
         end else if (pps_int_o && load_armed) begin
            vita_time_o <= held_time;
         end else begin
            vita_time_o <= vita_next;
         end
         if (commit_wr) begin
            load_armed <= ~set_data_i[0];
         end else if (pps_int_o) begin
            load_armed <= 1'b0;
         end
      end
   end

endmodule

// File: verilog/u2_ctrl_core.sv
/*
 * Radio core slow control
 * Settings-driven control pins, LEDs, timers, VITA time and
 * status readback on dsp_clk
 */
module u2_ctrl_core
   import u2_ctrl_pkg::*;
#(
   parameter int unsigned ticks_per_sec = TICKS_PER_SEC_DEFAULT
) (
   input  logic       dsp_clk,
   input  logic       reset_i,
   input  logic       set_stb_i,
   input  set_addr_t  set_addr_i,
   input  set_data_t  set_data_i,
   input  logic       rb_stb_i,
   input  rb_addr_t   rb_addr_i,
   input  logic       pps_i,
   input  logic       clk_status_i,
   input  logic       serdes_link_up_i,
   input  logic       phy_intn_i,
   input  logic       sim_mode_i,
   input  logic [3:0] clock_divider_i,
   output rb_word_t   rb_data_o,
   output logic       rb_ack_o,
   output logic       clock_ready_o,
   output logic [1:0] clk_en_o,
   output logic [1:0] clk_sel_o,
   output logic       ser_enable_o,
   output logic       ser_prbsen_o,
   output logic       ser_loopen_o,
   output logic       ser_rx_en_o,
   output logic       adc_oe_a_o,
   output logic       adc_on_a_o,
   output logic       adc_oe_b_o,
   output logic       adc_on_b_o,
   output logic       phy_resetn_o,
   output led_t       leds_o,
   output logic       onetime_int_o,
   output logic       periodic_int_o,
   output logic       pps_int_o
);

   clock_ctrl_t  clock_ctrl;
   serdes_ctrl_t serdes_ctrl;
   adc_ctrl_t    adc_ctrl;
   vita_time_t   vita_time;
   vita_time_t   vita_time_pps;
   rb_word_t     irq_word;
   rb_word_t     sim_word;
   logic         phy_int;

   //////////////////////////////
   // Control pins and LEDs
   //////////////////////////////
   misc_ctrl_regs u_misc (
      .dsp_clk, .reset_i, .set_stb_i, .set_addr_i, .set_data_i,
      .clk_status_i, .serdes_link_up_i,
      .clock_ctrl_o (clock_ctrl),
      .serdes_ctrl_o(serdes_ctrl),
      .adc_ctrl_o   (adc_ctrl),
      .phy_resetn_o, .leds_o
   );

   assign clock_ready_o = clock_ctrl.clock_ready;
   assign clk_en_o      = clock_ctrl.clk_en;
   assign clk_sel_o     = clock_ctrl.clk_sel;
   assign ser_enable_o  = serdes_ctrl.enable;
   assign ser_prbsen_o  = serdes_ctrl.prbsen;
   assign ser_loopen_o  = serdes_ctrl.loopen;
   assign ser_rx_en_o   = serdes_ctrl.rx_en;
   assign adc_oe_a_o    = adc_ctrl.oe_a;
   assign adc_on_a_o    = adc_ctrl.on_a;
   assign adc_oe_b_o    = adc_ctrl.oe_b;
   assign adc_on_b_o    = adc_ctrl.on_b;

   //////////////////////////////
   // Timers and time
   //////////////////////////////
   simple_timer u_timer (
      .dsp_clk, .reset_i, .set_stb_i, .set_addr_i, .set_data_i,
      .onetime_int_o, .periodic_int_o
   );

   time_64bit #(.ticks_per_sec(ticks_per_sec)) u_time (
      .dsp_clk, .reset_i, .set_stb_i, .set_addr_i, .set_data_i, .pps_i,
      .vita_time_o    (vita_time),
      .vita_time_pps_o(vita_time_pps),
      .pps_int_o
   );

   //////////////////////////////
   // Readback
   //////////////////////////////
   // PHY interrupt pin is open drain, active low
   assign phy_int = ~phy_intn_i;

   assign irq_word = {16'b0,
                      3'b0, periodic_int_o, clk_status_i, serdes_link_up_i, 2'b0,
                      pps_int_o, 2'b0, phy_int, 2'b0, onetime_int_o, 1'b0};

   assign sim_word = {sim_mode_i, 27'b0, clock_divider_i};

   readback_mux u_rb (
      .dsp_clk, .reset_i, .rb_stb_i, .rb_addr_i,
      .sim_word_i     (sim_word),
      .irq_word_i     (irq_word),
      .vita_time_i    (vita_time),
      .vita_time_pps_i(vita_time_pps),
      .rb_data_o, .rb_ack_o
   );

endmodule

// File: verilog/u2_ctrl_pkg.sv
/*
 * Radio core slow-control definitions
 * Settings bus addresses and widths, register payload types,
 * VITA time format and readback word map
 */
package u2_ctrl_pkg;

   //////////////////////////////
   // Settings bus
   //////////////////////////////
   localparam int SET_AW = 8;
   localparam int SET_DW = 32;

   typedef logic [SET_AW-1:0] set_addr_t;
   typedef logic [SET_DW-1:0] set_data_t;

   // Register bases, offsets added where used
   localparam set_addr_t SR_MISC     = 8'd0;
   localparam set_addr_t SR_SIMTIMER = 8'd8;
   localparam set_addr_t SR_TIME64   = 8'd10;

   //////////////////////////////
   // Control payloads
   //////////////////////////////
   typedef struct packed {
      logic       clock_ready;
      logic [1:0] clk_en;
      logic [1:0] clk_sel;
   } clock_ctrl_t;

   typedef struct packed {
      logic enable;
      logic prbsen;
      logic loopen;
      logic rx_en;
   } serdes_ctrl_t;

   typedef struct packed {
      logic oe_a;
      logic on_a;
      logic oe_b;
      logic on_b;
   } adc_ctrl_t;

   typedef logic [7:0] led_t;

   // Status LEDs start under hardware control
   localparam led_t LED_SRC_RESET = 8'b0001_1110;

   //////////////////////////////
   // Time and readback
   //////////////////////////////
   typedef struct packed {
      logic [31:0] secs;
      logic [31:0] ticks;
   } vita_time_t;

   localparam int unsigned TICKS_PER_SEC_DEFAULT = 100_000_000;

   typedef logic [3:0]  rb_addr_t;
   typedef logic [31:0] rb_word_t;

   // Bump when the register map changes
   localparam rb_word_t COMPAT_NUM = 32'd6;

   localparam rb_addr_t RB_SIM     = 4'd9;
   localparam rb_addr_t RB_TIME_HI = 4'd10;
   localparam rb_addr_t RB_TIME_LO = 4'd11;
   localparam rb_addr_t RB_COMPAT  = 4'd12;
   localparam rb_addr_t RB_IRQ     = 4'd13;
   localparam rb_addr_t RB_PPS_HI  = 4'd14;
   localparam rb_addr_t RB_PPS_LO  = 4'd15;

endpackage
